//--- flist.f
hw/ddr_rw_pkg.sv
hw/cas_latency_queue.sv
hw/rw_burst_ctrl.sv
hw/ddr_rw_top.sv
test/ddr_rw_assert.sv
test/ddr_rw_tb.sv

//--- hw/cas_latency_queue.sv
`timescale 1ns/1ps

module cas_latency_queue #(
  parameter int QUEUE_DEPTH = ddr_rw_pkg::default_queue_depth
) (
  input  logic                               ddr_intf,
  input  logic                               rst_n,
  input  logic                               cas_valid,
  input  ddr_rw_pkg::cas_kind_t              cas_is_read,
  input  ddr_rw_pkg::lat_t                   cl,
  input  ddr_rw_pkg::lat_t                   cwl,
  input  ddr_rw_pkg::lat_t                   al,
  input  ddr_rw_pkg::lat_t                   rd_pre,
  input  ddr_rw_pkg::lat_t                   wr_pre,
  input  ddr_rw_pkg::cycle_t                 now,
  input  logic                               head_pop,
  output logic                               head_valid,
  output ddr_rw_pkg::cycle_t                 head_due,
  output ddr_rw_pkg::cas_kind_t              head_kind,
  output logic [$clog2(QUEUE_DEPTH+1)-1:0]   queue_count
);

  import ddr_rw_pkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  cycle_t           due_mem [QUEUE_DEPTH];
  cas_kind_t        kind_mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  cycle_t           latency;
  logic             full;
  logic             do_push;
  logic             do_pop;

  // Pointers wrap explicitly so the depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(QUEUE_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  // Reads wait CL+AL+read preamble, writes wait CWL+AL+write preamble
  always_comb
  begin
    if (cas_is_read == cas_read)
      latency = cycle_t'(cl) + cycle_t'(al) + cycle_t'(rd_pre);
    else
      latency = cycle_t'(cwl) + cycle_t'(al) + cycle_t'(wr_pre);
  end

  assign full    = (count == CNT_W'(QUEUE_DEPTH));
  assign do_pop  = head_pop && head_valid;
  // A full queue still takes a command when the head leaves in the same cycle
  assign do_push = cas_valid && (!full || do_pop);

  // Entries carry an absolute due time, so nothing is rewritten after the push
  always_ff @(posedge ddr_intf)
  begin
    if (do_push)
    begin
      due_mem[wr_ptr]  <= now + latency;
      kind_mem[wr_ptr] <= cas_is_read;
    end
  end

  always_ff @(posedge ddr_intf)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_inc(rd_ptr);
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  assign head_valid  = (count != '0);
  assign head_due    = due_mem[rd_ptr];
  assign head_kind   = kind_mem[rd_ptr];
  assign queue_count = count;

endmodule

//--- hw/ddr_rw_pkg.sv
package ddr_rw_pkg;

  // Free-running cycle count, also used as an absolute due time
  typedef logic [15:0] cycle_t;

  // Mode register latency field (CL, CWL, AL and the preambles)
  typedef logic [5:0] lat_t;

  // CAS command kind
  typedef logic cas_kind_t;

  localparam cas_kind_t cas_read  = 1'b1;
  localparam cas_kind_t cas_write = 1'b0;

  // Data-phase controller states
  // rw_gap holds while entries are queued but none is due yet
  typedef enum logic [1:0]
  {
    rw_idle,
    rw_burst,
    rw_gap
  } rw_state_t;

  // Commands that may be outstanding at once
  localparam int default_queue_depth = 8;

  // BL8 occupies four clock cycles on a DDR bus
  localparam int default_burst_cycles = 4;

endpackage

//--- hw/ddr_rw_top.sv
`timescale 1ns/1ps

module ddr_rw_top #(
  parameter int QUEUE_DEPTH  = ddr_rw_pkg::default_queue_depth,
  parameter int BURST_CYCLES = ddr_rw_pkg::default_burst_cycles
) (
  input  logic                  ddr_intf,
  input  logic                  rst_n,
  input  logic                  cas_valid,
  input  ddr_rw_pkg::cas_kind_t cas_is_read,
  input  ddr_rw_pkg::lat_t      cl,
  input  ddr_rw_pkg::lat_t      cwl,
  input  ddr_rw_pkg::lat_t      al,
  input  ddr_rw_pkg::lat_t      rd_pre,
  input  ddr_rw_pkg::lat_t      wr_pre,
  output logic                  rd_rdy,
  output logic                  wr_rdy,
  output logic                  rd_burst,
  output logic                  wr_burst,
  output logic                  data_idle,
  output logic                  rw_done
);

  import ddr_rw_pkg::*;

  cycle_t                           now;
  logic                             head_valid;
  cycle_t                           head_due;
  cas_kind_t                        head_kind;
  logic                             head_pop;
  logic [$clog2(QUEUE_DEPTH+1)-1:0] queue_count;

  // Shared time base for the due stamps and the controller compare
  always_ff @(posedge ddr_intf)
  begin
    if (!rst_n)
      now <= '0;
    else
      now <= now + cycle_t'(1);
  end

  cas_latency_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .ddr_intf    (ddr_intf),
    .rst_n       (rst_n),
    .cas_valid   (cas_valid),
    .cas_is_read (cas_is_read),
    .cl          (cl),
    .cwl         (cwl),
    .al          (al),
    .rd_pre      (rd_pre),
    .wr_pre      (wr_pre),
    .now         (now),
    .head_pop    (head_pop),
    .head_valid  (head_valid),
    .head_due    (head_due),
    .head_kind   (head_kind),
    .queue_count (queue_count)
  );

  rw_burst_ctrl #(
    .QUEUE_DEPTH  (QUEUE_DEPTH),
    .BURST_CYCLES (BURST_CYCLES)
  ) u_ctrl (
    .ddr_intf    (ddr_intf),
    .rst_n       (rst_n),
    .now         (now),
    .head_valid  (head_valid),
    .head_due    (head_due),
    .head_kind   (head_kind),
    .queue_count (queue_count),
    .head_pop    (head_pop),
    .rd_rdy      (rd_rdy),
    .wr_rdy      (wr_rdy),
    .rd_burst    (rd_burst),
    .wr_burst    (wr_burst),
    .data_idle   (data_idle),
    .rw_done     (rw_done)
  );

endmodule

//--- hw/rw_burst_ctrl.sv
`timescale 1ns/1ps

module rw_burst_ctrl #(
  parameter int QUEUE_DEPTH  = ddr_rw_pkg::default_queue_depth,
  parameter int BURST_CYCLES = ddr_rw_pkg::default_burst_cycles
) (
  input  logic                               ddr_intf,
  input  logic                               rst_n,
  input  ddr_rw_pkg::cycle_t                 now,
  input  logic                               head_valid,
  input  ddr_rw_pkg::cycle_t                 head_due,
  input  ddr_rw_pkg::cas_kind_t              head_kind,
  input  logic [$clog2(QUEUE_DEPTH+1)-1:0]   queue_count,
  output logic                               head_pop,
  output logic                               rd_rdy,
  output logic                               wr_rdy,
  output logic                               rd_burst,
  output logic                               wr_burst,
  output logic                               data_idle,
  output logic                               rw_done
);

  import ddr_rw_pkg::*;

  localparam int BEAT_W = (BURST_CYCLES > 1) ? $clog2(BURST_CYCLES) : 1;

  rw_state_t         state;
  rw_state_t         state_nxt;
  logic [BEAT_W-1:0] beat;
  cas_kind_t         burst_kind;
  logic              in_burst;
  logic              last_beat;
  logic              head_due_next;
  logic              queue_empty;

  assign in_burst    = (state == rw_burst);
  assign last_beat   = (beat == BEAT_W'(BURST_CYCLES - 1));
  assign queue_empty = (queue_count == '0);

  // The decision is taken one cycle ahead, so the burst opens at the due edge
  assign head_due_next = head_valid && (head_due == now + cycle_t'(1));

  // A new burst may start from idle or gap, or chain on the last beat
  assign head_pop = head_due_next && (!in_burst || last_beat);

  always_comb
  begin
    state_nxt = state;
    case (state)
      rw_idle:
      begin
        if (head_pop)
          state_nxt = rw_burst;
        else if (head_valid)
          state_nxt = rw_gap;
      end
      rw_burst:
      begin
        if (last_beat)
        begin
          if (head_pop)
            state_nxt = rw_burst;
          else if (head_valid)
            state_nxt = rw_gap;
          else
            state_nxt = rw_idle;
        end
      end
      rw_gap:
      begin
        if (head_pop)
          state_nxt = rw_burst;
        else if (!head_valid)
          state_nxt = rw_idle;
      end
      default:
        state_nxt = rw_idle;
    endcase
  end

  always_ff @(posedge ddr_intf)
  begin
    if (!rst_n)
    begin
      state <= rw_idle;
      beat  <= '0;
    end
    else
    begin
      state <= state_nxt;
      // Restarting the count on a chained burst gives it a fresh ready pulse
      if (head_pop)
        beat <= '0;
      else if (in_burst && !last_beat)
        beat <= beat + 1'b1;
    end
  end

  always_ff @(posedge ddr_intf)
  begin
    if (head_pop)
      burst_kind <= head_kind;
  end

  assign rd_burst = in_burst && (burst_kind == cas_read);
  assign wr_burst = in_burst && (burst_kind == cas_write);
  assign rd_rdy   = rd_burst && (beat == '0);
  assign wr_rdy   = wr_burst && (beat == '0);

  assign data_idle = (state == rw_idle) && queue_empty;
  // Nothing pending beyond the beat on the bus right now
  assign rw_done   = queue_empty && ((state == rw_idle) || (in_burst && last_beat));

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module ddr_rw_tb \
  -f flist.f

# The pipe keeps the script going on a failing run, so the log decides
./obj_dir/Vddr_rw_tb | tee "$LOG"

if grep -q "Something failed" "$LOG"; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "Everything OK" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"

//--- test/ddr_rw_assert.sv
`timescale 1ns/1ps

module ddr_rw_assert #(
  parameter int QUEUE_DEPTH  = ddr_rw_pkg::default_queue_depth,
  parameter int BURST_CYCLES = ddr_rw_pkg::default_burst_cycles
) (
  input logic                             ddr_intf,
  input logic                             rst_n,
  input logic                             cas_valid,
  input logic                             head_pop,
  input logic                             head_valid,
  input ddr_rw_pkg::cycle_t               now,
  input ddr_rw_pkg::cycle_t               head_due,
  input logic [$clog2(QUEUE_DEPTH+1)-1:0] queue_count,
  input logic                             rd_rdy,
  input logic                             wr_rdy,
  input logic                             rd_burst,
  input logic                             wr_burst
);

  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam int GAP_W = $clog2(BURST_CYCLES + 1);

  logic [GAP_W-1:0] since_cas;
  logic [GAP_W-1:0] since_rdy;
  logic             any_rdy;

  assign any_rdy = rd_rdy || wr_rdy;

  // Cycles since the last CAS, saturating at the minimum spacing
  always_ff @(posedge ddr_intf)
  begin
    if (!rst_n)
      since_cas <= GAP_W'(BURST_CYCLES);
    else if (cas_valid)
      since_cas <= GAP_W'(1);
    else if (since_cas != GAP_W'(BURST_CYCLES))
      since_cas <= since_cas + 1'b1;
  end

  // Cycles since the last ready pulse also saturate at the burst length
  always_ff @(posedge ddr_intf)
  begin
    if (!rst_n)
      since_rdy <= GAP_W'(BURST_CYCLES);
    else if (any_rdy)
      since_rdy <= GAP_W'(1);
    else if (since_rdy != GAP_W'(BURST_CYCLES))
      since_rdy <= since_rdy + 1'b1;
  end

  cas_spacing: assert property (@(posedge ddr_intf) disable iff (!rst_n)
    cas_valid |-> since_cas == GAP_W'(BURST_CYCLES))
    else $error("CAS commands closer than the burst length");

  queue_room: assert property (@(posedge ddr_intf) disable iff (!rst_n)
    cas_valid |-> (queue_count < CNT_W'(QUEUE_DEPTH)) || head_pop)
    else $error("CAS issued into a full queue");

  // Chained bursts may follow each other exactly but never overlap
  rdy_spacing: assert property (@(posedge ddr_intf) disable iff (!rst_n)
    any_rdy |-> since_rdy == GAP_W'(BURST_CYCLES))
    else $error("Ready pulses closer than the burst length");

  // A burst level needs a ready pulse within the last burst length
  burst_window: assert property (@(posedge ddr_intf) disable iff (!rst_n)
    (rd_burst || wr_burst) |-> any_rdy || (since_rdy < GAP_W'(BURST_CYCLES)))
    else $error("Burst level outside the window of a ready pulse");

  // An entry still at the head when its due cycle arrives has been missed
  no_missed_due: assert property (@(posedge ddr_intf) disable iff (!rst_n)
    head_valid |-> head_due != now)
    else $error("Queued CAS passed its due cycle without a burst");

endmodule

bind ddr_rw_top ddr_rw_assert #(
  .QUEUE_DEPTH  (QUEUE_DEPTH),
  .BURST_CYCLES (BURST_CYCLES)
) u_assert (
  .ddr_intf    (ddr_intf),
  .rst_n       (rst_n),
  .cas_valid   (cas_valid),
  .head_pop    (head_pop),
  .head_valid  (head_valid),
  .now         (now),
  .head_due    (head_due),
  .queue_count (queue_count),
  .rd_rdy      (rd_rdy),
  .wr_rdy      (wr_rdy),
  .rd_burst    (rd_burst),
  .wr_burst    (wr_burst)
);

//--- test/ddr_rw_patterns.txt
// First line: cl cwl al rd_pre wr_pre, all hex
// Then one record per line: gap in cycles since the previous CAS, kind (1 read, 0 write), hex
// A gap of ffff ends the list
14 10 0a 02 01

// Single read, then a single write after the read has drained
05 1
40 0

// Four reads spaced by the burst length make one continuous burst
40 1
04 1
04 1
04 1

// Read then a write with a shorter latency, leaving a gap between the bursts
40 1
0b 0
04 1

// Eight reads in flight fill the queue
40 1
04 1
04 1
04 1
04 1
04 1
04 1
04 1

// Mixed kinds in flight, some chained and some with gaps
40 0
04 0
04 1
04 1
0c 0
04 0
04 1
0a 0

// End of the command list
ffff 0

//--- test/ddr_rw_tb.sv
`timescale 1ns/1ps

module ddr_rw_tb;

  import ddr_rw_pkg::*;

  localparam int QUEUE_DEPTH  = default_queue_depth;
  localparam int BURST_CYCLES = default_burst_cycles;
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 3;
  localparam int MAX_WORDS    = 128;
  localparam int MAX_CMDS     = 60;
  localparam logic [15:0] END_MARK = 16'hffff;

  logic      ddr_intf;
  logic      rst_n;
  logic      cas_valid;
  cas_kind_t cas_is_read;
  lat_t      cl;
  lat_t      cwl;
  lat_t      al;
  lat_t      rd_pre;
  lat_t      wr_pre;
  logic      rd_rdy;
  logic      wr_rdy;
  logic      rd_burst;
  logic      wr_burst;
  logic      data_idle;
  logic      rw_done;

  logic [15:0] pattern_mem [MAX_WORDS];
  int          n_cmds;
  int          cmd_gap [MAX_CMDS];
  cas_kind_t   cmd_kind [MAX_CMDS];

  // Commands in issue order, with the cycle each was driven and its latency
  int          issued;
  int          drive_cycle [MAX_CMDS];
  int          cmd_latency [MAX_CMDS];
  cas_kind_t   issued_kind [MAX_CMDS];

  int cyc;
  int bursts_seen;
  int last_end;
  int watchdog_cycles;
  bit loaded;
  bit monitor_on;

  ddr_rw_top #(
    .QUEUE_DEPTH  (QUEUE_DEPTH),
    .BURST_CYCLES (BURST_CYCLES)
  ) UUT (
    .ddr_intf    (ddr_intf),
    .rst_n       (rst_n),
    .cas_valid   (cas_valid),
    .cas_is_read (cas_is_read),
    .cl          (cl),
    .cwl         (cwl),
    .al          (al),
    .rd_pre      (rd_pre),
    .wr_pre      (wr_pre),
    .rd_rdy      (rd_rdy),
    .wr_rdy      (wr_rdy),
    .rd_burst    (rd_burst),
    .wr_burst    (wr_burst),
    .data_idle   (data_idle),
    .rw_done     (rw_done)
  );

  initial
  begin
    ddr_intf = 1'b0;
    forever #(CLK_PERIOD / 2) ddr_intf = ~ddr_intf;
  end

  // Own cycle count, so a CAS driven in cycle c bursts in cycle c plus its latency
  always @(posedge ddr_intf)
  begin
    if (!rst_n)
      cyc <= 0;
    else
      cyc <= cyc + 1;
  end

  function automatic int latency_of(input cas_kind_t kind);
    if (kind == cas_read)
      return int'(cl) + int'(al) + int'(rd_pre);
    return int'(cwl) + int'(al) + int'(wr_pre);
  endfunction

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_cycle(input string what, input cycle_t actual, input cycle_t expected);
    if (actual !== expected)
    begin
      $display("Fail at %0t ns: %s in cycle %0d, expected cycle %0d",
               $time, what, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_kind(input string what, input cas_kind_t actual,
                            input cas_kind_t expected);
    if (actual !== expected)
    begin
      $display("Fail at %0t ns: %s is %0d, expected %0d (1 read, 0 write)",
               $time, what, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_level(input string what, input logic actual, input logic expected);
    if (actual !== expected)
    begin
      $display("Fail at %0t ns: %s is %b in cycle %0d, expected %b",
               $time, what, actual, cyc, expected);
      abort_run();
    end
  endtask

  task automatic load_patterns();
    int idx;
    int gap_sum;
    int max_lat;
    $readmemh("test/ddr_rw_patterns.txt", pattern_mem);
    cl      = lat_t'(pattern_mem[0]);
    cwl     = lat_t'(pattern_mem[1]);
    al      = lat_t'(pattern_mem[2]);
    rd_pre  = lat_t'(pattern_mem[3]);
    wr_pre  = lat_t'(pattern_mem[4]);
    n_cmds  = 0;
    idx     = 5;
    gap_sum = 0;
    while (idx + 1 < MAX_WORDS && pattern_mem[idx] != END_MARK && n_cmds < MAX_CMDS)
    begin
      cmd_gap[n_cmds]  = int'(pattern_mem[idx]);
      cmd_kind[n_cmds] = pattern_mem[idx + 1][0];
      gap_sum          = gap_sum + cmd_gap[n_cmds];
      n_cmds           = n_cmds + 1;
      idx              = idx + 2;
    end
    if (n_cmds == 0 || latency_of(cas_read) < 3 || latency_of(cas_write) < 3)
    begin
      $display("The pattern file holds no commands or a latency below 3 cycles");
      abort_run();
    end
    max_lat = latency_of(cas_read);
    if (latency_of(cas_write) > max_lat)
      max_lat = latency_of(cas_write);
    watchdog_cycles = gap_sum + max_lat + 100;
  endtask

  // The strobe is held for one cycle, and the next CAS follows gap cycles after this one
  task automatic issue_cas(input int gap, input cas_kind_t kind);
    int lat;
    int burst_end;
    repeat (gap - 1) @(negedge ddr_intf);
    lat                 = latency_of(kind);
    cas_valid           = 1'b1;
    cas_is_read         = kind;
    drive_cycle[issued] = cyc;
    cmd_latency[issued] = lat;
    issued_kind[issued] = kind;
    issued              = issued + 1;
    burst_end           = cyc + lat + BURST_CYCLES - 1;
    if (burst_end > last_end)
      last_end = burst_end;
    @(negedge ddr_intf);
    cas_valid = 1'b0;
  endtask

  task automatic check_outputs();
    logic exp_rd_rdy;
    logic exp_wr_rdy;
    logic exp_rd_burst;
    logic exp_wr_burst;
    logic queued;
    logic busy;
    logic last_beat;
    int   start;
    exp_rd_rdy   = 1'b0;
    exp_wr_rdy   = 1'b0;
    exp_rd_burst = 1'b0;
    exp_wr_burst = 1'b0;
    queued       = 1'b0;
    busy         = 1'b0;
    last_beat    = 1'b0;
    // Bursts come out in issue order, so each ready pulse belongs to the next command
    if (rd_rdy || wr_rdy)
    begin
      if (bursts_seen >= issued)
      begin
        $display("A ready pulse came in cycle %0d with no command left to serve", cyc);
        abort_run();
      end
      else
      begin
        check_cycle("burst start", cycle_t'(cyc),
                    cycle_t'(drive_cycle[bursts_seen] + cmd_latency[bursts_seen]));
        check_kind("burst kind", rd_rdy ? cas_read : cas_write, issued_kind[bursts_seen]);
        bursts_seen = bursts_seen + 1;
      end
    end
    // An entry sits in the queue from the cycle after its CAS until its burst opens
    for (int i = 0; i < issued; i++)
    begin
      start = drive_cycle[i] + cmd_latency[i];
      if (cyc > drive_cycle[i] && cyc < start)
        queued = 1'b1;
      if (cyc >= start && cyc < start + BURST_CYCLES)
      begin
        busy = 1'b1;
        if (issued_kind[i] == cas_read)
        begin
          exp_rd_burst = 1'b1;
          exp_rd_rdy   = (cyc == start);
        end
        else
        begin
          exp_wr_burst = 1'b1;
          exp_wr_rdy   = (cyc == start);
        end
        if (cyc == start + BURST_CYCLES - 1)
          last_beat = 1'b1;
      end
    end
    check_level("rd_rdy", rd_rdy, exp_rd_rdy);
    check_level("wr_rdy", wr_rdy, exp_wr_rdy);
    check_level("rd_burst", rd_burst, exp_rd_burst);
    check_level("wr_burst", wr_burst, exp_wr_burst);
    check_level("data_idle", data_idle, !queued && !busy);
    check_level("rw_done", rw_done, !queued && (!busy || last_beat));
  endtask

  always @(negedge ddr_intf)
  begin
    if (monitor_on)
      check_outputs();
  end

  initial
  begin
    wait (loaded);
    #(watchdog_cycles * CLK_PERIOD);
    $display("Timeout: the bursts did not finish within %0d cycles", watchdog_cycles);
    abort_run();
  end

  initial
  begin
    rst_n       = 1'b0;
    cas_valid   = 1'b0;
    cas_is_read = cas_write;
    issued      = 0;
    bursts_seen = 0;
    last_end    = 0;
    monitor_on  = 1'b0;
    load_patterns();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(negedge ddr_intf);
    rst_n      = 1'b1;
    monitor_on = 1'b1;
    for (int i = 0; i < n_cmds; i++)
      issue_cas(cmd_gap[i], cmd_kind[i]);
    while (cyc <= last_end || !data_idle)
      @(negedge ddr_intf);
    @(posedge ddr_intf);
    if (bursts_seen != n_cmds)
    begin
      $display("Only %0d of %0d bursts were seen", bursts_seen, n_cmds);
      abort_run();
    end
    else
    begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule
